// ==== decode_mips32.sv ====
module decode_mips32 import decode_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input dec_in_t fetch,
	output logic uop_valid,
	output uop_t uop
);

	uop_t exec_cand;
	logic exec_hit;
	uop_t flow_cand;
	logic flow_hit;

	exec_decode exec_decode_i (
		.fetch(fetch),
		.cand(exec_cand),
		.hit(exec_hit)
	);

	flow_decode flow_decode_i (
		.fetch(fetch),
		.cand(flow_cand),
		.hit(flow_hit)
	);

	// the only register stage
	uop_merge uop_merge_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.pc(fetch.pc),
		.pht_idx(fetch.pht_idx),
		.exec_cand(exec_cand),
		.exec_hit(exec_hit),
		.flow_cand(flow_cand),
		.flow_hit(flow_hit),
		.uop_valid(uop_valid),
		.uop(uop)
	);

endmodule

// ==== decode_pkg.sv ====
package decode_pkg;

	localparam int M_WIDTH = 32;
	localparam int LG_PRF_ENTRIES = 6; // physical register specifier width
	localparam int LG_PHT_SZ = 8;
	localparam int IMM_W = 16;
	localparam int JMP_IMM_W = M_WIDTH - IMM_W; // upper half of a jump target

	typedef logic [LG_PRF_ENTRIES-1:0] preg_t;

	localparam preg_t REG_ZERO = preg_t'(0);
	localparam preg_t REG_RA = preg_t'(31); // link register
	localparam logic [31:0] INSN_EHB = 32'd192; // sll r0, r0, 3

	// primary opcode, insn[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'd0, OP_REGIMM = 6'd1, OP_J = 6'd2, OP_JAL = 6'd3,
		OP_BEQ = 6'd4, OP_BNE = 6'd5, OP_BLEZ = 6'd6, OP_BGTZ = 6'd7,
		OP_ADDIU = 6'd9, OP_SLTI = 6'd10, OP_SLTIU = 6'd11, OP_ANDI = 6'd12,
		OP_ORI = 6'd13, OP_XORI = 6'd14, OP_LUI = 6'd15,
		OP_BEQL = 6'd20, OP_BNEL = 6'd21, OP_BLEZL = 6'd22, OP_BGTZL = 6'd23,
		OP_LB = 6'd32, OP_LH = 6'd33, OP_LWL = 6'd34, OP_LW = 6'd35,
		OP_LBU = 6'd36, OP_LHU = 6'd37, OP_LWR = 6'd38,
		OP_SB = 6'd40, OP_SH = 6'd41, OP_SWL = 6'd42, OP_SW = 6'd43,
		OP_SWR = 6'd46, OP_LL = 6'd48, OP_PREF = 6'd51
	} major_e;

	// SPECIAL function field, insn[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3,
		FN_SLLV = 6'd4, FN_SRLV = 6'd6, FN_SRAV = 6'd7,
		FN_JR = 6'd8, FN_JALR = 6'd9, FN_SYNC = 6'd15,
		FN_ADDU = 6'd33, FN_SUBU = 6'd35,
		FN_AND = 6'd36, FN_OR = 6'd37, FN_XOR = 6'd38, FN_NOR = 6'd39,
		FN_SLT = 6'd42, FN_SLTU = 6'd43, FN_TEQ = 6'd52
	} funct_e;

	// REGIMM rt field, insn[20:16]
	typedef enum logic [4:0] {
		RI_BLTZ = 5'd0,
		RI_BGEZ = 5'd1,
		RI_BLTZL = 5'd2,
		RI_BGEZL = 5'd3,
		RI_BGEZAL = 5'd17
	} regimm_e;

	// II must stay at zero, a cleared record reads as illegal
	typedef enum logic [6:0] {
		II, NOP,
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		MOV, MOVI,
		BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
		BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL,
		J, JAL, JR, JALR,
		LB, LH, LW, LBU, LHU, LWL, LWR,
		SB, SH, SW, SWL, SWR
	} uop_op_e;

	typedef struct packed {
		logic [31:0] insn;
		logic [M_WIDTH-1:0] pc;
		logic pred; // predicted taken
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic [M_WIDTH-1:0] pred_target;
	} dec_in_t;

	typedef struct packed {
		uop_op_e op;
		preg_t src_a;
		logic src_a_valid;
		preg_t src_b;
		logic src_b_valid;
		preg_t dst;
		logic dst_valid;
		logic [IMM_W-1:0] imm;
		logic [JMP_IMM_W-1:0] jmp_imm;
		logic [M_WIDTH-1:0] pc;
		logic has_delay_slot;
		logic has_nullifying_delay_slot; // likely branches
		logic br_pred;
		logic is_br;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic is_mem;
		logic is_int;
		logic is_store;
	} uop_t;

endpackage

// ==== exec_decode.sv ====
module exec_decode import decode_pkg::*;
(
	input dec_in_t fetch,
	output uop_t cand,
	output logic hit
);

	major_e major;
	funct_e funct;
	preg_t rs;
	preg_t rt;
	preg_t rd;
	preg_t shamt;
	logic [IMM_W-1:0] imm;
	logic nop_alias;
	uop_t base;

	assign major = major_e'(fetch.insn[31:26]);
	assign funct = funct_e'(fetch.insn[5:0]);
	assign rs = preg_t'(fetch.insn[25:21]); // zero padded
	assign rt = preg_t'(fetch.insn[20:16]);
	assign rd = preg_t'(fetch.insn[15:11]);
	assign shamt = preg_t'(fetch.insn[10:6]);
	assign imm = fetch.insn[IMM_W-1:0];
	assign nop_alias = (fetch.insn == 32'd0) || (fetch.insn == INSN_EHB);

	// integer record; a zero destination folds to NOP
	function automatic uop_t int_rec(
		uop_t b, uop_op_e op,
		preg_t a, logic a_v, preg_t s, logic s_v,
		preg_t d, logic [IMM_W-1:0] i
	);
		uop_t u;
		u = b;
		u.op = (d == REG_ZERO) ? NOP : op;
		u.src_a = a;
		u.src_a_valid = a_v;
		u.src_b = s;
		u.src_b_valid = s_v;
		u.dst = d;
		u.dst_valid = (d != REG_ZERO);
		u.imm = i;
		u.is_int = 1'b1;
		return u;
	endfunction

	// load/store record; merge marks lwl/lwr which also read rt
	function automatic uop_t mem_rec(
		uop_t b, uop_op_e op, preg_t a, preg_t t,
		logic [IMM_W-1:0] i, logic store, logic merge
	);
		uop_t u;
		u = b;
		u.op = op;
		u.src_a = a;
		u.src_a_valid = 1'b1;
		u.src_b = (store || merge) ? t : REG_ZERO;
		u.src_b_valid = store || merge;
		if (!store)
		begin
			u.dst = t;
			u.dst_valid = (t != REG_ZERO); // no write to r0
		end
		u.imm = i;
		u.is_mem = 1'b1;
		u.is_store = store;
		return u;
	endfunction

	always_comb
	begin
		base = '0;
		base.op = II;
		base.pc = fetch.pc;
		base.pht_idx = fetch.pht_idx;
	end

	always_comb
	begin
		cand = base;
		hit = 1'b1;
		case (major)
			OP_SPECIAL:
			begin
				case (funct)
					FN_SLL: cand = int_rec(base, nop_alias ? NOP : SLL,
						rt, 1'b1, shamt, 1'b0, rd, '0); // shamt rides in src_b
					FN_SRL: cand = int_rec(base, SRL, rt, 1'b1, shamt, 1'b0, rd, '0);
					FN_SRA: cand = int_rec(base, SRA, rt, 1'b1, shamt, 1'b0, rd, '0);
					FN_SLLV: cand = int_rec(base, SLLV, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_SRLV: cand = int_rec(base, SRLV, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_SRAV: cand = int_rec(base, SRAV, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_ADDU: cand = int_rec(base, ADDU, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_SUBU: cand = int_rec(base, SUBU, rs, 1'b1, rt, 1'b1, rd, '0);
					FN_AND: cand = int_rec(base, AND, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_XOR: cand = int_rec(base, XOR, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_NOR: cand = int_rec(base, NOR, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_SLT: cand = int_rec(base, SLT, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_SLTU: cand = int_rec(base, SLTU, rt, 1'b1, rs, 1'b1, rd, '0);
					FN_OR:
					begin
						if (rs == REG_ZERO) // or rd, r0, rt is a move
							cand = int_rec(base, MOV, rt, 1'b1, REG_ZERO, 1'b0, rd, '0);
						else
							cand = int_rec(base, OR, rt, 1'b1, rs, 1'b1, rd, '0);
					end
					FN_SYNC, FN_TEQ:
					begin
						cand.op = NOP;
						cand.is_int = 1'b1;
					end
					default: hit = 1'b0; // jr/jalr go to flow_decode
				endcase
			end
			OP_ADDIU:
			begin
				if (rs == REG_ZERO)
					cand = int_rec(base, MOVI, REG_ZERO, 1'b0, REG_ZERO, 1'b0, rt, imm);
				else
					cand = int_rec(base, ADDIU, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
			end
			OP_SLTI: cand = int_rec(base, SLTI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
			OP_SLTIU: cand = int_rec(base, SLTIU, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
			OP_ANDI: cand = int_rec(base, ANDI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
			OP_ORI: cand = int_rec(base, ORI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
			OP_XORI: cand = int_rec(base, XORI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
			OP_LUI: cand = int_rec(base, LUI, REG_ZERO, 1'b0, REG_ZERO, 1'b0, rt, imm);
			OP_LB: cand = mem_rec(base, LB, rs, rt, imm, 1'b0, 1'b0);
			OP_LH: cand = mem_rec(base, LH, rs, rt, imm, 1'b0, 1'b0);
			OP_LW: cand = mem_rec(base, LW, rs, rt, imm, 1'b0, 1'b0);
			OP_LL: cand = mem_rec(base, LW, rs, rt, imm, 1'b0, 1'b0); // plain load
			OP_LBU: cand = mem_rec(base, LBU, rs, rt, imm, 1'b0, 1'b0);
			OP_LHU: cand = mem_rec(base, LHU, rs, rt, imm, 1'b0, 1'b0);
			OP_LWL: cand = mem_rec(base, LWL, rs, rt, imm, 1'b0, 1'b1);
			OP_LWR: cand = mem_rec(base, LWR, rs, rt, imm, 1'b0, 1'b1);
			OP_SB: cand = mem_rec(base, SB, rs, rt, imm, 1'b1, 1'b0);
			OP_SH: cand = mem_rec(base, SH, rs, rt, imm, 1'b1, 1'b0);
			OP_SW: cand = mem_rec(base, SW, rs, rt, imm, 1'b1, 1'b0);
			OP_SWL: cand = mem_rec(base, SWL, rs, rt, imm, 1'b1, 1'b0);
			OP_SWR: cand = mem_rec(base, SWR, rs, rt, imm, 1'b1, 1'b0);
			OP_PREF:
			begin
				cand.op = NOP; // prefetch hint dropped
				cand.is_int = 1'b1;
			end
			default: hit = 1'b0;
		endcase
	end

	// store flag must agree with the store ops in the table
	assert property (@(fetch)
		cand.is_store == (cand.op inside {SB, SH, SW, SWL, SWR}))
		else $error("exec_decode: store flag does not match op");

endmodule

// ==== flow_decode.sv ====
module flow_decode import decode_pkg::*;
(
	input dec_in_t fetch,
	output uop_t cand,
	output logic hit
);

	major_e major;
	funct_e funct;
	regimm_e regimm;
	preg_t rs;
	preg_t rt;
	preg_t rd;
	uop_t idle;

	assign major = major_e'(fetch.insn[31:26]);
	assign funct = funct_e'(fetch.insn[5:0]);
	assign regimm = regimm_e'(fetch.insn[20:16]);
	assign rs = preg_t'(fetch.insn[25:21]);
	assign rt = preg_t'(fetch.insn[20:16]);
	assign rd = preg_t'(fetch.insn[15:11]);

	function automatic uop_op_e cond_op(major_e m);
		case (m)
			OP_BEQ: return BEQ;
			OP_BNE: return BNE;
			OP_BLEZ: return BLEZ;
			OP_BGTZ: return BGTZ;
			OP_BEQL: return BEQL;
			OP_BNEL: return BNEL;
			OP_BLEZL: return BLEZL;
			OP_BGTZL: return BGTZL;
			default: return II;
		endcase
	endfunction

	always_comb
	begin
		idle = '0;
		idle.op = II;
		idle.pc = fetch.pc;
		idle.pht_idx = fetch.pht_idx;
	end

	always_comb
	begin
		cand = idle;
		hit = 1'b1;
		cand.is_br = 1'b1;
		cand.is_int = 1'b1;
		cand.has_delay_slot = 1'b1;
		case (major)
			OP_SPECIAL:
			begin
				cand.src_a = rs;
				cand.src_a_valid = 1'b1;
				cand.imm = fetch.pred_target[IMM_W-1:0]; // predicted target split in two
				cand.jmp_imm = fetch.pred_target[M_WIDTH-1:IMM_W];
				case (funct)
					FN_JR: cand.op = JR;
					FN_JALR:
					begin
						cand.op = JALR;
						cand.dst = rd;
						cand.dst_valid = (rd != REG_ZERO);
					end
					default: hit = 1'b0;
				endcase
			end
			OP_REGIMM:
			begin
				cand.src_a = rs;
				cand.src_a_valid = 1'b1;
				cand.imm = fetch.insn[IMM_W-1:0];
				cand.br_pred = fetch.pred;
				case (regimm)
					RI_BLTZ: cand.op = BLTZ;
					RI_BGEZ: cand.op = BGEZ;
					RI_BLTZL:
					begin
						cand.op = BLTZL;
						cand.has_nullifying_delay_slot = 1'b1;
					end
					RI_BGEZL:
					begin
						cand.op = BGEZL;
						cand.has_nullifying_delay_slot = 1'b1;
					end
					RI_BGEZAL:
					begin
						cand.op = (rs == REG_ZERO) ? BAL : BGEZAL; // r0 >= 0 always taken
						cand.dst = REG_RA;
						cand.dst_valid = 1'b1;
						cand.src_b = REG_RA;
						cand.src_b_valid = (rs != REG_ZERO);
					end
					default: cand.op = II; // claimed but illegal
				endcase
			end
			OP_J: cand.op = J; // target folded in fetch
			OP_JAL:
			begin
				cand.op = JAL;
				cand.imm = fetch.insn[IMM_W-1:0];
				cand.jmp_imm = {{(JMP_IMM_W-10){1'b0}}, fetch.insn[25:16]};
				cand.dst = REG_RA;
				cand.dst_valid = 1'b1;
				cand.br_pred = 1'b1;
			end
			OP_BEQ, OP_BNE, OP_BEQL, OP_BNEL, OP_BLEZ, OP_BGTZ, OP_BLEZL, OP_BGTZL:
			begin
				cand.op = cond_op(major);
				cand.src_a = rs;
				cand.src_a_valid = 1'b1;
				cand.src_b = fetch.insn[27] ? REG_ZERO : rt; // blez/bgtz compare with zero
				cand.src_b_valid = !fetch.insn[27];
				cand.imm = fetch.insn[IMM_W-1:0];
				cand.br_pred = fetch.pred;
				cand.has_nullifying_delay_slot = fetch.insn[30]; // likely forms
			end
			default: hit = 1'b0;
		endcase
		if (!hit)
			cand = idle;
	end

	// likely flag taken from opcode bits must match the op table
	assert property (@(fetch) hit |->
		(cand.has_nullifying_delay_slot ==
			(cand.op inside {BEQL, BNEL, BLEZL, BGTZL, BLTZL, BGEZL})))
		else $error("flow_decode: likely flag does not match op");

endmodule

// ==== sim.f ====
+incdir+.
decode_pkg.sv
exec_decode.sv
flow_decode.sv
uop_merge.sv
decode_mips32.sv
tb_decode_mips32.sv

// ==== decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// empty record, keeps only pc and pht_idx
function automatic uop_t blank_rec(dec_in_t f);
	uop_t u;
	u = '0;
	u.op = II;
	u.pc = f.pc;
	u.pht_idx = f.pht_idx;
	return u;
endfunction

function automatic uop_t alu_rec(dec_in_t f, uop_op_e op, preg_t a, logic av,
	preg_t b, logic bv, preg_t d, logic [IMM_W-1:0] imm);
	uop_t u;
	u = blank_rec(f);
	u.op = (d == REG_ZERO) ? NOP : op; // write to r0 is a nop
	u.src_a = a;
	u.src_a_valid = av;
	u.src_b = b;
	u.src_b_valid = bv;
	u.dst = d;
	u.dst_valid = (d != REG_ZERO);
	u.imm = imm;
	u.is_int = 1'b1;
	return u;
endfunction

function automatic uop_t mem_rec(dec_in_t f, uop_op_e op, logic store, logic reads_rt);
	uop_t u;
	preg_t rt;
	rt = preg_t'(f.insn[20:16]);
	u = blank_rec(f);
	u.op = op;
	u.src_a = preg_t'(f.insn[25:21]);
	u.src_a_valid = 1'b1;
	if (store || reads_rt)
	begin
		u.src_b = rt;
		u.src_b_valid = 1'b1;
	end
	if (!store)
	begin
		u.dst = rt;
		u.dst_valid = (rt != REG_ZERO);
	end
	u.imm = f.insn[15:0];
	u.is_mem = 1'b1;
	u.is_store = store;
	return u;
endfunction

function automatic uop_t br_rec(dec_in_t f, uop_op_e op);
	uop_t u;
	u = blank_rec(f);
	u.op = op;
	u.is_br = 1'b1;
	u.is_int = 1'b1;
	u.has_delay_slot = 1'b1;
	return u;
endfunction

// beq/bne compare two regs, blez/bgtz only rs
function automatic uop_t cond_rec(dec_in_t f, uop_op_e op, logic two_reg, logic likely);
	uop_t u;
	u = br_rec(f, op);
	u.src_a = preg_t'(f.insn[25:21]);
	u.src_a_valid = 1'b1;
	if (two_reg)
	begin
		u.src_b = preg_t'(f.insn[20:16]);
		u.src_b_valid = 1'b1;
	end
	u.imm = f.insn[15:0];
	u.br_pred = f.pred;
	u.has_nullifying_delay_slot = likely;
	return u;
endfunction

function automatic uop_t decode_ref(dec_in_t f);
	uop_t u;
	logic [5:0] opc;
	logic [5:0] fn;
	preg_t rs;
	preg_t rt;
	preg_t rd;
	preg_t sh;
	logic [15:0] imm;
	opc = f.insn[31:26];
	fn = f.insn[5:0];
	rs = preg_t'(f.insn[25:21]);
	rt = preg_t'(f.insn[20:16]);
	rd = preg_t'(f.insn[15:11]);
	sh = preg_t'(f.insn[10:6]);
	imm = f.insn[15:0];
	u = blank_rec(f);
	case (opc)
		OP_SPECIAL:
		begin
			case (fn)
				FN_SLL:
				begin
					if (f.insn == 32'd0 || f.insn == INSN_EHB)
						u = alu_rec(f, NOP, rt, 1'b1, sh, 1'b0, rd, '0);
					else
						u = alu_rec(f, SLL, rt, 1'b1, sh, 1'b0, rd, '0);
				end
				FN_SRL: u = alu_rec(f, SRL, rt, 1'b1, sh, 1'b0, rd, '0);
				FN_SRA: u = alu_rec(f, SRA, rt, 1'b1, sh, 1'b0, rd, '0);
				FN_SLLV: u = alu_rec(f, SLLV, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_SRLV: u = alu_rec(f, SRLV, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_SRAV: u = alu_rec(f, SRAV, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_ADDU: u = alu_rec(f, ADDU, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_SUBU: u = alu_rec(f, SUBU, rs, 1'b1, rt, 1'b1, rd, '0); // rs first
				FN_AND: u = alu_rec(f, AND, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_XOR: u = alu_rec(f, XOR, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_NOR: u = alu_rec(f, NOR, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_SLT: u = alu_rec(f, SLT, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_SLTU: u = alu_rec(f, SLTU, rt, 1'b1, rs, 1'b1, rd, '0);
				FN_OR:
				begin
					if (rs == REG_ZERO)
						u = alu_rec(f, MOV, rt, 1'b1, REG_ZERO, 1'b0, rd, '0);
					else
						u = alu_rec(f, OR, rt, 1'b1, rs, 1'b1, rd, '0);
				end
				FN_JR, FN_JALR:
				begin
					u = br_rec(f, (fn == FN_JR) ? JR : JALR);
					u.src_a = rs;
					u.src_a_valid = 1'b1;
					u.imm = f.pred_target[15:0];
					u.jmp_imm = f.pred_target[31:16];
					if (fn == FN_JALR)
					begin
						u.dst = rd;
						u.dst_valid = (rd != REG_ZERO);
					end
				end
				FN_SYNC, FN_TEQ:
				begin
					u.op = NOP;
					u.is_int = 1'b1;
				end
				default: u = blank_rec(f);
			endcase
		end
		OP_REGIMM:
		begin
			u = br_rec(f, II); // unknown rt stays illegal
			u.src_a = rs;
			u.src_a_valid = 1'b1;
			u.imm = imm;
			u.br_pred = f.pred;
			case (f.insn[20:16])
				RI_BLTZ: u.op = BLTZ;
				RI_BGEZ: u.op = BGEZ;
				RI_BLTZL, RI_BGEZL:
				begin
					u.op = (f.insn[16]) ? BGEZL : BLTZL;
					u.has_nullifying_delay_slot = 1'b1;
				end
				RI_BGEZAL:
				begin
					u.op = (rs == REG_ZERO) ? BAL : BGEZAL;
					u.dst = REG_RA;
					u.dst_valid = 1'b1;
					u.src_b = REG_RA;
					u.src_b_valid = (rs != REG_ZERO);
				end
				default: u.op = II;
			endcase
		end
		OP_J: u = br_rec(f, J);
		OP_JAL:
		begin
			u = br_rec(f, JAL);
			u.imm = imm;
			u.jmp_imm = {6'd0, f.insn[25:16]};
			u.dst = REG_RA;
			u.dst_valid = 1'b1;
			u.br_pred = 1'b1;
		end
		OP_BEQ: u = cond_rec(f, BEQ, 1'b1, 1'b0);
		OP_BNE: u = cond_rec(f, BNE, 1'b1, 1'b0);
		OP_BLEZ: u = cond_rec(f, BLEZ, 1'b0, 1'b0);
		OP_BGTZ: u = cond_rec(f, BGTZ, 1'b0, 1'b0);
		OP_BEQL: u = cond_rec(f, BEQL, 1'b1, 1'b1);
		OP_BNEL: u = cond_rec(f, BNEL, 1'b1, 1'b1);
		OP_BLEZL: u = cond_rec(f, BLEZL, 1'b0, 1'b1);
		OP_BGTZL: u = cond_rec(f, BGTZL, 1'b0, 1'b1);
		OP_ADDIU:
		begin
			if (rs == REG_ZERO)
				u = alu_rec(f, MOVI, REG_ZERO, 1'b0, REG_ZERO, 1'b0, rt, imm);
			else
				u = alu_rec(f, ADDIU, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
		end
		OP_SLTI: u = alu_rec(f, SLTI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
		OP_SLTIU: u = alu_rec(f, SLTIU, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
		OP_ANDI: u = alu_rec(f, ANDI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
		OP_ORI: u = alu_rec(f, ORI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
		OP_XORI: u = alu_rec(f, XORI, rs, 1'b1, REG_ZERO, 1'b0, rt, imm);
		OP_LUI: u = alu_rec(f, LUI, REG_ZERO, 1'b0, REG_ZERO, 1'b0, rt, imm);
		OP_LB: u = mem_rec(f, LB, 1'b0, 1'b0);
		OP_LH: u = mem_rec(f, LH, 1'b0, 1'b0);
		OP_LW, OP_LL: u = mem_rec(f, LW, 1'b0, 1'b0);
		OP_LBU: u = mem_rec(f, LBU, 1'b0, 1'b0);
		OP_LHU: u = mem_rec(f, LHU, 1'b0, 1'b0);
		OP_LWL: u = mem_rec(f, LWL, 1'b0, 1'b1); // merges into old rt
		OP_LWR: u = mem_rec(f, LWR, 1'b0, 1'b1);
		OP_SB: u = mem_rec(f, SB, 1'b1, 1'b0);
		OP_SH: u = mem_rec(f, SH, 1'b1, 1'b0);
		OP_SW: u = mem_rec(f, SW, 1'b1, 1'b0);
		OP_SWL: u = mem_rec(f, SWL, 1'b1, 1'b0);
		OP_SWR: u = mem_rec(f, SWR, 1'b1, 1'b0);
		OP_PREF:
		begin
			u.op = NOP;
			u.is_int = 1'b1;
		end
		default: u = blank_rec(f);
	endcase
	return u;
endfunction

task automatic check_uop(string name, uop_t exp, uop_t act);
	if (exp !== act)
	begin
		uop_errors++;
		$display("ERR %s expected %h (%s) actual %h (%s)", name, exp, exp.op.name(),
			act, act.op.name());
	end
endtask

task automatic check_valid(string name, logic exp, logic act);
	if (exp !== act)
	begin
		valid_errors++;
		$display("ERR %s uop_valid expected %b actual %b", name, exp, act);
	end
endtask

`endif

// ==== tb_decode_mips32.sv ====
module tb_decode_mips32 import decode_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 8;
	localparam int RAND_COUNT = 2000;
	localparam int MARGIN = 50;

	logic clk;
	logic arst_n;
	logic in_valid;
	dec_in_t fetch;
	logic uop_valid;
	uop_t uop;

	int uop_errors;
	int valid_errors;
	int seed;
	int cycles;
	int limit;
	string cur_name;
	string exp_name;
	logic exp_valid;
	uop_t exp_uop;
	dec_in_t cases[$];
	string case_names[$];

	`include "decode_ref.svh"

	decode_mips32 decode_mips32_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.fetch(fetch),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	initial
		clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] r_enc(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [4:0] sh, logic [5:0] fn);
		return {6'd0, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_enc(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// random metadata around a fixed instruction word
	function automatic dec_in_t make_fetch(logic [31:0] insn);
		dec_in_t f;
		f.insn = insn;
		f.pc = $random(seed);
		f.pred = $random(seed);
		f.pht_idx = $random(seed);
		f.pred_target = $random(seed);
		return f;
	endfunction

	task automatic add_case(string name, logic [31:0] insn);
		cases.push_back(make_fetch(insn));
		case_names.push_back(name);
	endtask

	task automatic build_cases();
		logic [5:0] fns[14];
		logic [5:0] imm_ops[7];
		logic [5:0] mem_ops[13];
		logic [5:0] br_ops[8];
		logic [4:0] ri[5];
		fns = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
			FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
		imm_ops = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		mem_ops = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWL, OP_LWR, OP_LL,
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
		br_ops = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL};
		ri = '{RI_BLTZ, RI_BGEZ, RI_BLTZL, RI_BGEZL, RI_BGEZAL};
		foreach (fns[i])
		begin
			add_case("alu_r", r_enc(5'd3, 5'd4, 5'd5, 5'd7, fns[i]));
			add_case("alu_r_rd0", r_enc(5'd3, 5'd4, 5'd0, 5'd7, fns[i]));
		end
		foreach (imm_ops[i])
		begin
			add_case("alu_i", i_enc(imm_ops[i], 5'd6, 5'd9, 16'h8123));
			add_case("alu_i_rt0", i_enc(imm_ops[i], 5'd6, 5'd0, 16'h0042));
		end
		add_case("sll_zero", 32'd0);
		add_case("ehb", INSN_EHB);
		add_case("mov", r_enc(5'd0, 5'd4, 5'd5, 5'd0, FN_OR));
		add_case("movi", i_enc(OP_ADDIU, 5'd0, 5'd9, 16'hbeef));
		add_case("sync", r_enc(5'd0, 5'd0, 5'd0, 5'd0, FN_SYNC));
		add_case("teq", r_enc(5'd2, 5'd3, 5'd0, 5'd0, FN_TEQ));
		add_case("pref", i_enc(OP_PREF, 5'd4, 5'd1, 16'h0010));
		foreach (mem_ops[i])
			add_case("mem", i_enc(mem_ops[i], 5'd5, 5'd12, 16'hfffc));
		add_case("load_rt0", i_enc(OP_LW, 5'd5, 5'd0, 16'h0008));
		foreach (br_ops[i])
			add_case("branch", i_enc(br_ops[i], 5'd7, 5'd8, 16'hfff0));
		foreach (ri[i])
			add_case("regimm", i_enc(OP_REGIMM, 5'd7, ri[i], 16'h0020));
		add_case("bal", i_enc(OP_REGIMM, 5'd0, RI_BGEZAL, 16'h0030));
		add_case("regimm_unknown", i_enc(OP_REGIMM, 5'd7, 5'd9, 16'h0030));
		add_case("j", {OP_J, 26'h1234567});
		add_case("jal", {OP_JAL, 26'h2abcdef});
		add_case("jr", r_enc(5'd9, 5'd0, 5'd0, 5'd0, FN_JR));
		add_case("jalr", r_enc(5'd9, 5'd0, 5'd31, 5'd0, FN_JALR));
		add_case("jalr_rd0", r_enc(5'd9, 5'd0, 5'd0, 5'd0, FN_JALR));
		add_case("cop0", {6'd16, 26'h0800000});
		add_case("cop1", {6'd17, 26'h0200000});
		add_case("mult", r_enc(5'd3, 5'd4, 5'd0, 5'd0, 6'd24));
		add_case("lwc1", i_enc(6'd49, 5'd5, 5'd2, 16'h0004));
		add_case("swc1", i_enc(6'd57, 5'd5, 5'd2, 16'h0004));
		add_case("unused_op", i_enc(6'd63, 5'd1, 5'd2, 16'h0003));
	endtask

	// expected values follow the DUT by one edge
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exp_valid <= 1'b0;
			exp_uop <= '0;
			exp_name <= "reset";
		end
		else
		begin
			exp_valid <= in_valid;
			exp_name <= cur_name;
			if (in_valid)
				exp_uop <= decode_ref(fetch);
		end
	end

	// uop is checked while idle too, so a hold failure shows up
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			check_valid(exp_name, exp_valid, uop_valid);
			check_uop(exp_name, exp_uop, uop);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout: run went past %0d cycles without finishing", limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] insn;
		logic [31:0] r;
		int idx;
		seed = 32'hd5cda539;
		uop_errors = 0;
		valid_errors = 0;
		cycles = 0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		fetch = '0;
		cur_name = "reset";
		build_cases();
		limit = RESET_CYCLES + IDLE_CYCLES + cases.size() + RAND_COUNT + 4 + MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		cur_name <= "idle";
		repeat (IDLE_CYCLES) @(posedge clk);
		foreach (cases[i])
		begin
			fetch <= cases[i];
			in_valid <= 1'b1;
			cur_name <= case_names[i];
			@(posedge clk);
		end
		for (int n = 0; n < RAND_COUNT; n++)
		begin
			r = $random(seed);
			insn = $random(seed);
			if (r[1:0] != 2'd0)
			begin
				// mutate a directed encoding, funct kept for SPECIAL
				idx = (r[31:8] % cases.size());
				if (cases[idx].insn[31:26] == OP_SPECIAL)
					insn = {6'd0, insn[25:6], cases[idx].insn[5:0]};
				else
					insn = {cases[idx].insn[31:26], insn[25:0]};
			end
			fetch <= make_fetch(insn);
			in_valid <= r[2] | r[3];
			cur_name <= "random";
			@(posedge clk);
		end
		in_valid <= 1'b0;
		cur_name <= "drain";
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		$display("uop errors: %0d, valid errors: %0d", uop_errors, valid_errors);
		if (uop_errors == 0 && valid_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== uop_merge.sv ====
module uop_merge import decode_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [M_WIDTH-1:0] pc,
	input logic [LG_PHT_SZ-1:0] pht_idx,
	input uop_t exec_cand,
	input logic exec_hit,
	input uop_t flow_cand,
	input logic flow_hit,
	output logic uop_valid,
	output uop_t uop
);

	uop_t sel;

	// at most one decoder claims an encoding
	always_comb
	begin
		if (exec_hit)
			sel = exec_cand;
		else if (flow_hit)
			sel = flow_cand;
		else
		begin
			sel = '0; // illegal, only pc and pht_idx kept
			sel.op = II;
			sel.pc = pc;
			sel.pht_idx = pht_idx;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			uop_valid <= 1'b0;
			uop <= '0;
		end
		else
		begin
			uop_valid <= in_valid;
			if (in_valid)
				uop <= sel; // holds while idle
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> !(exec_hit && flow_hit))
		else $error("uop_merge: both decoders claimed the instruction");

	// folding in the decoders keeps r0 out of rename
	assert property (@(posedge clk) disable iff (!arst_n)
		(uop_valid && uop.dst_valid) |-> (uop.dst != REG_ZERO))
		else $error("uop_merge: valid write to r0");

endmodule
